// ==== bubble_loader.f ====
hdl/bubble_pkg.sv
hdl/page_converter.sv
hdl/spi_flash_reader.sv
hdl/loop_mask_writer.sv
hdl/bubble_loader.sv
test/flash_model.sv
test/tb_bubble_loader.sv

// ==== hdl/bubble_loader.sv ====
`timescale 1ns/10ps

module bubble_loader import bubble_pkg::*;
(
    input  logic      MCLK,
    input  logic      arst_n,
    input  img_t      img_num,
    input  acc_t      acc_type,
    input  pos_t      abs_pos,
    input  logic      spi_miso,
    output page_t     curr_page,
    output logic      spi_cs_n,
    output logic      spi_clk,
    output logic      spi_mosi,
    output logic      out_wr_en,
    output outaddr_t  out_wr_addr,
    output logic      out_wr_data,
    output logic      fifo_en,
    output logic      fifo_wr_en,
    output fifoaddr_t fifo_wr_addr,
    output logic      fifo_wr_data,
    output logic      fifo_send_boot,
    output logic      fifo_send_user
);

    logic       conv_start;
    pos_t       conv_pos;
    logic       conv_done;
    logic       bit_val;
    logic       bit_strobe;
    logic [1:0] mode;
    logic       mask_req;
    logic       loop_good;
    logic       phase_start;
    logic       access_end;

    page_converter page_converter_i (
        .MCLK       (MCLK),
        .arst_n     (arst_n),
        .conv_start (conv_start),
        .conv_pos   (conv_pos),
        .conv_done  (conv_done),
        .conv_page  (curr_page)     // held page also feeds the reader
    );

    spi_flash_reader spi_flash_reader_i (
        .MCLK           (MCLK),
        .arst_n         (arst_n),
        .acc_type       (acc_type),
        .img_num        (img_num),
        .abs_pos        (abs_pos),
        .conv_start     (conv_start),
        .conv_pos       (conv_pos),
        .conv_done      (conv_done),
        .conv_page      (curr_page),
        .spi_cs_n       (spi_cs_n),
        .spi_clk        (spi_clk),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .bit_val        (bit_val),
        .bit_strobe     (bit_strobe),
        .mode           (mode),
        .mask_req       (mask_req),
        .loop_good      (loop_good),
        .phase_start    (phase_start),
        .access_end     (access_end),
        .fifo_en        (fifo_en),
        .fifo_send_boot (fifo_send_boot),
        .fifo_send_user (fifo_send_user)
    );

    loop_mask_writer loop_mask_writer_i (
        .MCLK         (MCLK),
        .arst_n       (arst_n),
        .mode         (mode),
        .phase_start  (phase_start),
        .bit_val      (bit_val),
        .bit_strobe   (bit_strobe),
        .mask_req     (mask_req),
        .access_end   (access_end),
        .loop_good    (loop_good),
        .out_wr_en    (out_wr_en),
        .out_wr_addr  (out_wr_addr),
        .out_wr_data  (out_wr_data),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_addr (fifo_wr_addr),
        .fifo_wr_data (fifo_wr_data)
    );

endmodule

// ==== hdl/bubble_pkg.sv ====
package bubble_pkg;

    typedef logic [11:0] pos_t;       // absolute bubble position
    typedef logic [11:0] page_t;      // flash page number
    typedef logic [2:0]  img_t;
    typedef logic [2:0]  acc_t;       // bit 1 active, bit 0 user page
    typedef logic [14:0] outaddr_t;
    typedef logic [12:0] fifoaddr_t;
    typedef logic [11:0] mapaddr_t;
    typedef logic [11:0] cnt_t;

    typedef enum logic [4:0] {
        idle, cmd_load, cmd_shift_lo, cmd_shift_hi,
        boot_setup, boot_lo, boot_hi, boot_write, boot_next,
        map_setup, map_lo, map_hi, map_write, map_next,
        head_read, head_write, head_next,
        page_lo, page_hi, page_write, page_next,
        send_wait
    } spi_state_t;

    localparam logic [7:0] spi_read_op   = 8'h03;
    localparam page_t      boot_page     = 12'h805;
    localparam page_t      page_count    = 12'd2053;
    localparam int         page_stride   = 3;          // interleave factor
    localparam cnt_t       boot_bits     = 12'd2656;
    localparam cnt_t       map_bits      = 12'd1200;
    localparam cnt_t       head_bits     = 12'd6;      // good loops ahead of page data
    localparam cnt_t       page_bits     = 12'd1030;
    localparam outaddr_t   page_out_base = 15'd14336;
    localparam cnt_t       cmd_bits      = 12'd32;

    // access type codes seen while the emulator sends
    localparam acc_t acc_boot_send = 3'b110;
    localparam acc_t acc_user_send = 3'b111;

    // what the result stage does with a reported bit
    localparam logic [1:0] mode_boot = 2'd0;
    localparam logic [1:0] mode_map  = 2'd1;
    localparam logic [1:0] mode_page = 2'd2;
    localparam logic [1:0] mode_head = 2'd3;

endpackage

// ==== hdl/loop_mask_writer.sv ====
`timescale 1ns/10ps

module loop_mask_writer import bubble_pkg::*;
(
    input  logic       MCLK,
    input  logic       arst_n,
    input  logic [1:0] mode,
    input  logic       phase_start,
    input  logic       bit_val,
    input  logic       bit_strobe,
    input  logic       mask_req,
    input  logic       access_end,
    output logic       loop_good,
    output logic       out_wr_en,
    output outaddr_t   out_wr_addr,
    output logic       out_wr_data,
    output logic       fifo_wr_en,
    output fifoaddr_t  fifo_wr_addr,
    output logic       fifo_wr_data
);

    logic     mask_tbl [4096];    // 1 = good loop
    mapaddr_t map_wr_ptr;
    mapaddr_t map_rd_ptr;
    logic     map_we;

    assign map_we    = bit_strobe && (mode == mode_map);
    assign out_wr_en = bit_strobe;

    // head bits carry the mask itself and bad page loops read as zero
    assign out_wr_data = (mode == mode_head) ? loop_good :
                         (mode == mode_page) ? (bit_val & loop_good) : bit_val;

    assign fifo_wr_en   = bit_strobe && (mode != mode_head) &&
                          ((mode != mode_page) || loop_good);
    assign fifo_wr_data = bit_val;

    always_ff @(posedge MCLK)
    begin
        if (map_we)
            mask_tbl[{map_wr_ptr[11:4], ~map_wr_ptr[3:0]}] <= bit_val;  // nibble flipped
        if (mask_req)
            loop_good <= mask_tbl[map_rd_ptr];
    end

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            map_wr_ptr <= '0;
            map_rd_ptr <= '0;
        end
        else if (access_end)
        begin
            map_wr_ptr <= '0;
            map_rd_ptr <= '0;
        end
        else
        begin
            if (map_we)
                map_wr_ptr <= map_wr_ptr + 12'd1;
            if (mask_req)
                map_rd_ptr <= map_rd_ptr + 12'd1;
        end
    end

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_wr_addr  <= '0;
            fifo_wr_addr <= '0;
        end
        else if (phase_start)
        begin
            out_wr_addr  <= (mode == mode_boot) ? outaddr_t'(0) : page_out_base;
            fifo_wr_addr <= '0;
        end
        else
        begin
            if (bit_strobe)
                out_wr_addr <= out_wr_addr + 15'd1;
            if (fifo_wr_en)
                fifo_wr_addr <= fifo_wr_addr + 13'd1;   // good bits only
        end
    end

    // a page write follows the mask read of its own loop
    a_no_bad_fifo: assert property (@(posedge MCLK) disable iff (!arst_n)
        (mode == mode_page && fifo_wr_en) |-> loop_good && $past(mask_req, 2));

endmodule

// ==== hdl/page_converter.sv ====
`timescale 1ns/10ps

module page_converter import bubble_pkg::*;
(
    input  logic  MCLK,
    input  logic  arst_n,
    input  logic  conv_start,
    input  pos_t  conv_pos,
    output logic  conv_done,
    output page_t conv_page
);

    typedef enum logic [1:0] {
        cv_idle,
        cv_add,
        cv_sub
    } conv_state_t;

    conv_state_t state;
    logic [13:0] acc;          // up to 3 * 4095
    pos_t        pos_r;
    logic [1:0]  add_cnt;

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= cv_idle;
            acc       <= '0;
            pos_r     <= '0;
            add_cnt   <= '0;
            conv_done <= 1'b0;
            conv_page <= '0;
        end
        else
        begin
            conv_done <= 1'b0;
            case (state)
                cv_idle:
                    if (conv_start)
                    begin
                        acc     <= '0;
                        pos_r   <= conv_pos;
                        add_cnt <= '0;
                        state   <= cv_add;
                    end
                cv_add:
                begin
                    acc     <= acc + 14'(pos_r);
                    add_cnt <= add_cnt + 2'd1;
                    if (add_cnt == 2'(page_stride - 1))
                        state <= cv_sub;
                end
                cv_sub:
                    if (acc >= 14'(page_count))
                        acc <= acc - 14'(page_count);    // one wrap per cycle
                    else
                    begin
                        conv_page <= acc[11:0];
                        conv_done <= 1'b1;
                        state     <= cv_idle;
                    end
                default:
                    state <= cv_idle;
            endcase
        end
    end

    // iterative result against the direct interleave formula
    a_page_range: assert property (@(posedge MCLK) disable iff (!arst_n)
        conv_done |-> (conv_page < page_count) &&
                      (int'(conv_page) == (page_stride * int'(pos_r)) % int'(page_count)));

endmodule

// ==== hdl/spi_flash_reader.sv ====
`timescale 1ns/10ps

module spi_flash_reader import bubble_pkg::*;
(
    input  logic       MCLK,
    input  logic       arst_n,
    input  acc_t       acc_type,
    input  img_t       img_num,
    input  pos_t       abs_pos,
    output logic       conv_start,
    output pos_t       conv_pos,
    input  logic       conv_done,
    input  page_t      conv_page,
    output logic       spi_cs_n,
    output logic       spi_clk,
    output logic       spi_mosi,
    input  logic       spi_miso,
    output logic       bit_val,
    output logic       bit_strobe,
    output logic [1:0] mode,
    output logic       mask_req,
    input  logic       loop_good,
    output logic       phase_start,
    output logic       access_end,
    output logic       fifo_en,
    output logic       fifo_send_boot,
    output logic       fifo_send_user
);

    spi_state_t  state;
    logic [31:0] cmd_sr;       // instruction, MSB goes out first
    cnt_t        cnt;
    logic        acc_user;     // acc_type[0] taken at start

    assign bit_strobe = (state == boot_write) || (state == map_write) ||
                        (state == head_write) || (state == page_write);
    assign mask_req   = (state == head_read) || (state == page_lo);

    always_ff @(posedge MCLK)
    begin
        if (state == idle)
            conv_pos <= abs_pos + 12'd1;    // controller counts the page ahead
        if (state == cmd_load && conv_done)
            cmd_sr <= {spi_read_op, 2'b00, img_num, acc_user ? conv_page : boot_page, 7'd0};
        else if (state == cmd_shift_lo)
            cmd_sr <= {cmd_sr[30:0], 1'b0};
        if (state == boot_hi || state == map_hi || state == page_hi)
            bit_val <= spi_miso;
    end

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state          <= idle;
            spi_cs_n       <= 1'b1;
            spi_clk        <= 1'b1;
            spi_mosi       <= 1'b0;
            cnt            <= '0;
            acc_user       <= 1'b0;
            mode           <= mode_boot;
            conv_start     <= 1'b0;
            phase_start    <= 1'b0;
            access_end     <= 1'b0;
            fifo_en        <= 1'b0;
            fifo_send_boot <= 1'b0;
            fifo_send_user <= 1'b0;
        end
        else
        begin
            conv_start  <= 1'b0;
            phase_start <= 1'b0;
            access_end  <= 1'b0;
            case (state)
                idle:
                    if (acc_type[1])
                    begin
                        acc_user   <= acc_type[0];
                        conv_start <= 1'b1;
                        state      <= cmd_load;
                    end
                cmd_load:
                    if (conv_done)
                    begin
                        spi_cs_n <= 1'b0;
                        fifo_en  <= 1'b1;
                        cnt      <= '0;
                        state    <= cmd_shift_lo;
                    end
                cmd_shift_lo:
                begin
                    spi_clk  <= 1'b0;
                    spi_mosi <= cmd_sr[31];
                    cnt      <= cnt + 12'd1;
                    state    <= cmd_shift_hi;
                end
                cmd_shift_hi:
                begin
                    spi_clk <= 1'b1;
                    if (cnt != cmd_bits)
                        state <= cmd_shift_lo;
                    else if (acc_user)
                    begin
                        mode        <= mode_head;
                        phase_start <= 1'b1;
                        cnt         <= '0;
                        state       <= head_read;
                    end
                    else
                        state <= boot_setup;
                end
                boot_setup:
                begin
                    mode        <= mode_boot;
                    phase_start <= 1'b1;
                    cnt         <= '0;
                    state       <= boot_lo;
                end
                boot_lo:
                begin
                    spi_clk <= 1'b0;
                    state   <= boot_hi;
                end
                boot_hi:
                begin
                    spi_clk <= 1'b1;
                    state   <= boot_write;
                end
                boot_write:
                    state <= boot_next;
                boot_next:
                    if (cnt == boot_bits - 12'd1)
                        state <= map_setup;
                    else
                    begin
                        cnt   <= cnt + 12'd1;
                        state <= boot_lo;
                    end
                map_setup:
                begin
                    mode  <= mode_map;      // output addresses carry on
                    cnt   <= '0;
                    state <= map_lo;
                end
                map_lo:
                begin
                    spi_clk <= 1'b0;
                    state   <= map_hi;
                end
                map_hi:
                begin
                    spi_clk <= 1'b1;
                    state   <= map_write;
                end
                map_write:
                    state <= map_next;
                map_next:
                    if (cnt == map_bits - 12'd1)
                    begin
                        spi_cs_n <= 1'b1;
                        state    <= send_wait;
                    end
                    else
                    begin
                        cnt   <= cnt + 12'd1;
                        state <= map_lo;
                    end
                head_read:
                    state <= head_write;
                head_write:
                    state <= head_next;
                head_next:
                    if (!loop_good)
                        state <= head_read;
                    else if (cnt == head_bits - 12'd1)
                    begin
                        mode  <= mode_page;
                        cnt   <= '0;
                        state <= page_lo;
                    end
                    else
                    begin
                        cnt   <= cnt + 12'd1;
                        state <= head_read;
                    end
                page_lo:
                begin
                    spi_clk <= ~loop_good;  // stays high when repeating a bad loop
                    state   <= page_hi;
                end
                page_hi:
                begin
                    spi_clk <= 1'b1;
                    state   <= page_write;
                end
                page_write:
                    state <= page_next;
                page_next:
                    if (!loop_good)
                        state <= page_lo;
                    else if (cnt == page_bits - 12'd1)
                    begin
                        spi_cs_n <= 1'b1;
                        state    <= send_wait;
                    end
                    else
                    begin
                        cnt   <= cnt + 12'd1;
                        state <= page_lo;
                    end
                send_wait:
                begin
                    fifo_en        <= 1'b0;
                    fifo_send_boot <= (acc_type == acc_boot_send);
                    fifo_send_user <= (acc_type == acc_user_send);
                    if (!acc_type[1])
                    begin
                        fifo_send_boot <= 1'b0;
                        fifo_send_user <= 1'b0;
                        access_end     <= 1'b1;
                        state          <= idle;
                    end
                end
                default:
                    state <= idle;
            endcase
        end
    end

    a_cs_idle: assert property (@(posedge MCLK) disable iff (!arst_n)
        (state == idle || state == send_wait) |-> spi_cs_n);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_bubble_loader -f bubble_loader.f \
    || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_bubble_loader 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx '>>> PASS' && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== test/flash_model.sv ====
`timescale 1ns/10ps

module flash_model import bubble_pkg::*;
(
    input  logic spi_cs_n,
    input  logic spi_clk,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic [31:0] cmd = '0;      // opcode and 24-bit address
    int          cmd_cnt = 0;
    int          rd_idx = 0;    // bit index since the address

    // content rule of the emulated flash
    function automatic logic bit_at(input logic [31:0] c, input int idx);
        logic [23:0] baddr;
        logic [7:0]  val;
        logic [2:0]  sel;
        if (c[31:24] != spi_read_op)
            return 1'b0;                                    // only the read op answers
        if (c[18:7] == boot_page && idx >= int'(boot_bits) &&
            idx < int'(boot_bits) + int'(map_bits))
            return (idx % 13) != 0;                         // loop mask behind the bootloader
        baddr = c[23:0] + 24'(idx / 8);
        val   = baddr[7:0] ^ baddr[15:8] ^ baddr[23:16];
        sel   = 3'(7 - idx % 8);                            // MSB first
        return val[sel];
    endfunction

    always @(posedge spi_cs_n or posedge spi_clk or negedge spi_clk)
    begin
        if (spi_cs_n !== 1'b0)
        begin
            cmd_cnt  <= 0;                                  // deselected, wait for a new op
            rd_idx   <= 0;
            spi_miso <= 1'b0;
        end
        else if (spi_clk === 1'b1)
        begin
            if (cmd_cnt < 32)
            begin
                cmd     <= {cmd[30:0], spi_mosi};
                cmd_cnt <= cmd_cnt + 1;
            end
        end
        else if (cmd_cnt == 32)
        begin
            spi_miso <= bit_at(cmd, rd_idx);                // next bit on the falling edge
            rd_idx   <= rd_idx + 1;
        end
    end

endmodule

// ==== test/tb_bubble_loader.sv ====
`timescale 1ns/10ps

module tb_bubble_loader import bubble_pkg::*;
();

    localparam int wait_limit = 200000;

    logic      MCLK = 1'b0;
    logic      arst_n;
    img_t      img_num;
    acc_t      acc_type;
    pos_t      abs_pos;
    logic      spi_miso;
    page_t     curr_page;
    logic      spi_cs_n;
    logic      spi_clk;
    logic      spi_mosi;
    logic      out_wr_en;
    outaddr_t  out_wr_addr;
    logic      out_wr_data;
    logic      fifo_en;
    logic      fifo_wr_en;
    fifoaddr_t fifo_wr_addr;
    logic      fifo_wr_data;
    logic      fifo_send_boot;
    logic      fifo_send_user;

    // expected write streams for the capture process
    outaddr_t  exp_out_addr[$];
    logic      exp_out_data[$];
    fifoaddr_t exp_fifo_addr[$];
    logic      exp_fifo_data[$];
    outaddr_t  exp_out_end;
    fifoaddr_t exp_fifo_end;
    string     test_name = "reset";

    always #2 MCLK = ~MCLK;

    bubble_loader bubble_loader_i (.*);

    flash_model flash_i (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_page(input string name, input page_t exp, input page_t act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_outaddr(input string name, input outaddr_t exp, input outaddr_t act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_fifoaddr(input string name, input fifoaddr_t exp, input fifoaddr_t act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    endtask

    // flash content as seen by a read of one page
    function automatic logic ref_flash_bit(input img_t img, input page_t page, input int idx);
        logic [23:0] byte_addr;
        logic [7:0]  byte_val;
        logic [2:0]  bit_sel;
        if (page == boot_page && idx >= int'(boot_bits) &&
            idx < int'(boot_bits) + int'(map_bits))
            return (idx % 13) != 0;
        byte_addr = {2'b00, img, page, 7'd0} + 24'(idx / 8);
        byte_val  = byte_addr[23:16] ^ byte_addr[15:8] ^ byte_addr[7:0];
        bit_sel   = 3'(7 - idx % 8);
        return byte_val[bit_sel];
    endfunction

    function automatic page_t ref_page(input pos_t pos);
        return page_t'((page_stride * (int'(pos) + 1)) % int'(page_count));
    endfunction

    // mask read in plain order and written with the low nibble flipped
    function automatic logic ref_loop_good(input int r);
        mapaddr_t rd;
        mapaddr_t wr;
        rd = mapaddr_t'(r);
        wr = {rd[11:4], ~rd[3:0]};
        return ref_flash_bit(img_t'(0), boot_page, int'(boot_bits) + int'(wr));
    endfunction

    function automatic void clear_expected();
        exp_out_addr.delete();
        exp_out_data.delete();
        exp_fifo_addr.delete();
        exp_fifo_data.delete();
    endfunction

    function automatic void build_boot_expected(input img_t img);
        logic b;
        clear_expected();
        for (int i = 0; i < int'(boot_bits) + int'(map_bits); i++)
        begin
            b = ref_flash_bit(img, boot_page, i);
            exp_out_addr.push_back(outaddr_t'(i));
            exp_out_data.push_back(b);
            exp_fifo_addr.push_back(fifoaddr_t'(i));
            exp_fifo_data.push_back(b);
        end
        exp_out_end  = outaddr_t'(int'(boot_bits) + int'(map_bits));
        exp_fifo_end = fifoaddr_t'(int'(boot_bits) + int'(map_bits));
    endfunction

    function automatic void build_user_expected(input img_t img, input page_t page);
        int        r;
        int        goods;
        int        k;
        outaddr_t  a;
        fifoaddr_t f;
        logic      g;
        clear_expected();
        r     = 0;
        goods = 0;
        k     = 0;
        a     = page_out_base;
        f     = '0;
        while (goods < int'(head_bits))     // head carries the mask itself
        begin
            g = ref_loop_good(r);
            r++;
            exp_out_addr.push_back(a);
            exp_out_data.push_back(g);
            a = a + 15'd1;
            if (g)
                goods++;
        end
        while (k < int'(page_bits))
        begin
            g = ref_loop_good(r);
            r++;
            exp_out_addr.push_back(a);
            a = a + 15'd1;
            if (g)
            begin
                exp_out_data.push_back(ref_flash_bit(img, page, k));
                exp_fifo_addr.push_back(f);
                exp_fifo_data.push_back(ref_flash_bit(img, page, k));
                f = f + 13'd1;
                k++;
            end
            else
                exp_out_data.push_back(1'b0);   // bad loop leaves the flash unclocked
        end
        exp_out_end  = a;
        exp_fifo_end = f;
    endfunction

    // capture and compare every buffer write
    always @(negedge MCLK)
    begin
        if (arst_n === 1'b1 && out_wr_en === 1'b1)
        begin
            if (exp_out_addr.size() == 0)
                report_failure($sformatf("%s: output buffer write past the expected stream",
                                         test_name));
            else
            begin
                check_outaddr({test_name, " out addr"}, exp_out_addr.pop_front(), out_wr_addr);
                check_bit($sformatf("%s out data @%0d", test_name, out_wr_addr),
                          exp_out_data.pop_front(), out_wr_data);
            end
        end
        if (arst_n === 1'b1 && fifo_wr_en === 1'b1)
        begin
            if (exp_fifo_addr.size() == 0)
                report_failure($sformatf("%s: FIFO write past the expected stream", test_name));
            else
            begin
                check_fifoaddr({test_name, " fifo addr"}, exp_fifo_addr.pop_front(), fifo_wr_addr);
                check_bit($sformatf("%s fifo data @%0d", test_name, fifo_wr_addr),
                          exp_fifo_data.pop_front(), fifo_wr_data);
            end
        end
    end

    task automatic wait_send(input logic boot_lvl, input logic user_lvl, input string what);
        int n;
        n = 0;
        while ((fifo_send_boot !== boot_lvl || fifo_send_user !== user_lvl) && n < wait_limit)
        begin
            @(negedge MCLK);
            n++;
        end
        if (fifo_send_boot !== boot_lvl || fifo_send_user !== user_lvl)
            report_failure($sformatf("%s: timed out waiting for %s", test_name, what));
    endtask

    task automatic finish_access();
        check_bit({test_name, " spi_cs_n at end"}, 1'b1, spi_cs_n);
        check_outaddr({test_name, " final out addr"}, exp_out_end, out_wr_addr);
        check_fifoaddr({test_name, " fifo write count"}, exp_fifo_end, fifo_wr_addr);
        if (exp_out_addr.size() != 0 || exp_fifo_addr.size() != 0)
            report_failure($sformatf("%s: access ended with %0d output and %0d FIFO writes missing",
                                     test_name, exp_out_addr.size(), exp_fifo_addr.size()));
        @(negedge MCLK);
        acc_type = 3'b000;
        wait_send(1'b0, 1'b0, "return to idle");
        @(negedge MCLK);                    // mask pointers clear here
    endtask

    task automatic run_boot_access();
        img_t img;
        img       = img_t'($urandom_range(0, 7));
        test_name = $sformatf("boot img %0d", img);
        build_boot_expected(img);
        @(negedge MCLK);
        img_num  = img;
        acc_type = acc_boot_send;
        wait_send(1'b1, 1'b0, "fifo_send_boot");
        finish_access();
    endtask

    task automatic run_user_access();
        img_t  img;
        pos_t  pos;
        page_t page;
        img       = img_t'($urandom_range(0, 7));
        pos       = pos_t'($urandom_range(0, 4094));
        page      = ref_page(pos);
        test_name = $sformatf("user img %0d pos %0d", img, pos);
        build_user_expected(img, page);
        @(negedge MCLK);
        img_num  = img;
        abs_pos  = pos;
        acc_type = acc_user_send;
        wait_send(1'b0, 1'b1, "fifo_send_user");
        check_page({test_name, " curr_page"}, page, curr_page);
        finish_access();
    endtask

    initial
    begin
        void'($urandom(32'h55b0));
        arst_n   = 1'b0;
        img_num  = '0;
        acc_type = '0;
        abs_pos  = '0;
        repeat (10) @(negedge MCLK);
        arst_n = 1'b1;
        @(negedge MCLK);
        check_bit("reset spi_cs_n", 1'b1, spi_cs_n);
        check_bit("reset spi_clk", 1'b1, spi_clk);
        check_bit("reset out_wr_en", 1'b0, out_wr_en);
        check_bit("reset fifo_wr_en", 1'b0, fifo_wr_en);
        check_bit("reset fifo_en", 1'b0, fifo_en);
        check_bit("reset fifo_send_boot", 1'b0, fifo_send_boot);
        check_bit("reset fifo_send_user", 1'b0, fifo_send_user);
        run_boot_access();                  // also loads the loop mask
        repeat (5) run_user_access();
        $display(">>> PASS");
        $finish;
    end

endmodule
